// File: dv/cpuTrace.txt
// kind 1 program word: pc word. kind 2 register write: index value
// kind 3 memory write: address value. kind 4 halt: halt pc, irq cycle
1 00 04010005  2 01 00000005
1 01 0402FFF0  2 02 FFFFFFF0
1 02 08230002  2 03 00000003
1 03 40041234  2 04 12340000
1 04 10845678  2 04 12345678
1 05 0C850FF0  2 05 00000670
1 06 1486FFFF  2 06 EDCBA987
1 07 18270002  2 07 FFFFFFF8
1 08 1C280004  2 08 00000050
1 09 20490004  2 09 0FFFFFFF
1 0a 244A0002  2 0a FFFFFFFC
1 0b 284B0001  2 0b 00000001
1 0c 2C2C0007  2 0c 00000000
1 0d 302D0000  2 0d FFFFFFFA
1 0e 348E0000  2 0e 12345679
1 0f 382F0000  2 0f 00000004
1 10 3C910000  2 11 0000000D
// r-type add, sub, sra, popcount, sgt
1 11 00239001  2 12 00000008
1 12 00619802  2 13 FFFFFFFE
1 13 00CFA009  2 14 FEDCBA98
1 14 00E0A80F  2 15 0000001D
1 15 0022B00B  2 16 00000001
1 16 48240003  3 08 12345678
1 17 44770005  2 17 12345678
1 18 5120C000  2 18 0FFFFFFF
1 19 5401C800  2 19 00000005
1 1a 548CD000
// bmi taken, bpl taken, bz not taken
1 1b 84400001
1 1c 041B00EE
1 1d 88200001
1 1e 041B00EE
1 1f 8C200001
1 20 041B0011  2 1b 00000011
1 21 8D800001
1 22 041B00EE
1 23 84200001
1 24 041C0022  2 1c 00000022
1 25 88400001
1 26 041D0033  2 1d 00000033
// call links 28 and lands on 2a
1 27 98000002  2 10 00000028
1 28 041B00EE
1 29 041B00EE
1 2a 80000001
1 2b 041B00EE
1 2c 061E0001  2 1e 00000029
1 2d 90000000
1 2e 94000000
4 2d 000000FA

// File: tb.f
logic/cpuPkg.sv
logic/controlUnit.sv
logic/aluExec.sv
logic/branchUnit.sv
logic/regFile.sv
logic/dataMem.sv
logic/cpuCore.sv
dv/tbCpu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tbCpu -f tb.f -o simCpu &&
    ./obj_dir/simCpu > sim.log 2>&1 ||
    echo "build or simulation reported an error"
[ -f sim.log ] && cat sim.log
grep -q "^TEST OK$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// File: dv/tbCpu.sv
`timescale 1ns/100ps

module tbCpu;
    import cpuPkg::*;

    logic    clk;
    logic    rst;
    wordT    instr;
    logic    irq;
    pcT      pc;
    logic    regWrEn;
    regIdxT  regWrAddr;
    wordT    regWrData;
    logic    memWrEn;
    memAddrT memWrAddr;
    wordT    memWrData;

    logic [31:0] traceMem [1024];
    wordT        progMem [256];
    logic        progValid [256];
    logic [31:0] expKind [$];
    logic [31:0] expAddr [$];
    wordT        expData [$];
    int          progLen;
    pcT          haltPc;
    int          irqCycle;
    int          cycleLimit;
    int          cycleCount;
    logic        traceLoaded;
    logic        sawHalt;

    cpuCore DUT (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .irq       (irq),
        .pc        (pc),
        .regWrEn   (regWrEn),
        .regWrAddr (regWrAddr),
        .regWrData (regWrData),
        .memWrEn   (memWrEn),
        .memWrAddr (memWrAddr),
        .memWrData (memWrData)
    );

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch at %0t: %s is %h, expected %h",
                              $time, what, actual, expected));
        end
    endtask

    // a record is three hex words giving kind then index or address then value
    task automatic loadTrace();
        logic [31:0] kind;
        for (int a = 0; a < 256; a++) begin
            progMem[a]   = {6'h3f, 18'h0, a[7:0]};
            progValid[a] = 1'b0;
        end
        for (int w = 0; w < $size(traceMem); w++) begin
            traceMem[w] = '0;
        end
        $readmemh("dv/cpuTrace.txt", traceMem);
        for (int i = 0; i + 2 < $size(traceMem) && traceMem[i] != 0; i += 3) begin
            kind = traceMem[i];
            case (kind)
                32'd1: begin
                    progMem[traceMem[i + 1][7:0]]   = traceMem[i + 2];
                    progValid[traceMem[i + 1][7:0]] = 1'b1;
                    progLen++;
                end
                32'd2, 32'd3: begin
                    expKind.push_back(kind);
                    expAddr.push_back(traceMem[i + 1]);
                    expData.push_back(traceMem[i + 2]);
                end
                32'd4: begin
                    haltPc   = traceMem[i + 1][7:0];
                    irqCycle = traceMem[i + 2];
                end
                default: failRun("trace file holds an unknown record kind");
            endcase
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // instruction memory answers pc
    always @(posedge clk) begin
        #1;
        instr = progMem[pc];
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (traceLoaded && cycleCount >= cycleLimit) begin
            failRun($sformatf("Run did not finish within %0d cycles", cycleLimit));
        end
    end

    // every write must match the next expected event
    always @(negedge clk) begin
        if (!rst && (regWrEn || memWrEn)) begin
            if (expKind.size() == 0) begin
                failRun("A register or memory write happened when none was expected");
            end else begin
                if (regWrEn) begin
                    checkValue(32'd2, expKind[0], "write kind (2 register, 3 memory)");
                    checkValue(32'(regWrAddr), expAddr[0], "register index");
                    checkValue(regWrData, expData[0], "register write data");
                end else begin
                    checkValue(32'd3, expKind[0], "write kind (2 register, 3 memory)");
                    checkValue(32'(memWrAddr), expAddr[0], "memory address");
                    checkValue(memWrData, expData[0], "memory write data");
                end
                void'(expKind.pop_front());
                void'(expAddr.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && traceLoaded) begin
            if (pc != pcT'(haltPc + 8'd2) && !progValid[pc]) begin
                failRun($sformatf("Execution reached pc %h, which holds no program word", pc));
            end
            if (pc == haltPc) begin
                sawHalt = 1'b1;
            end
            // halt must park pc until irq
            if (sawHalt && !irq) begin
                checkValue(32'(pc), 32'(haltPc), "pc while halted");
            end
        end
    end

    initial begin
        rst         = 1'b1;
        irq         = 1'b0;
        instr       = '0;
        cycleCount  = 0;
        progLen     = 0;
        irqCycle    = 0;
        haltPc      = '0;
        sawHalt     = 1'b0;
        traceLoaded = 1'b0;
        loadTrace();
        if (irqCycle == 0) begin
            failRun("Trace file has no halt record");
        end
        cycleLimit  = 6 * progLen + irqCycle + 50;
        traceLoaded = 1'b1;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        while (cycleCount < irqCycle) @(negedge clk);
        @(posedge clk);
        #1;
        checkValue(32'(pc), 32'(haltPc), "pc when irq rises");
        irq = 1'b1;

        while (pc == haltPc) @(negedge clk);
        checkValue(32'(pc), 32'(haltPc) + 32'd1, "pc after irq releases halt");
        // the nop after halt has to retire too
        while (pc == pcT'(haltPc + 8'd1)) @(negedge clk);
        checkValue(32'(pc), 32'(haltPc) + 32'd2, "pc after the final nop");

        if (expKind.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            failRun($sformatf("Run ended with %0d expected writes never seen", expKind.size()));
        end
    end

endmodule

// File: logic/cpuCore.sv
`timescale 1ns/100ps

module cpuCore (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::wordT    instr,
    input  logic            irq,
    output cpuPkg::pcT      pc,
    output logic            regWrEn,
    output cpuPkg::regIdxT  regWrAddr,
    output cpuPkg::wordT    regWrData,
    output logic            memWrEn,
    output cpuPkg::memAddrT memWrAddr,
    output cpuPkg::wordT    memWrData
);
    import cpuPkg::*;

    aluOpT   aluOp;
    brOpT    brOp;
    logic    aluSrc;
    logic    regAluOut;
    logic    rdMem;
    logic    wrMem;
    logic    wrReg;
    logic    mToReg;
    logic    linkSel;
    logic    updPc;
    logic    isCmov;
    logic    rtZero;
    wordT    rsData;
    wordT    rtData;
    wordT    aluResult;
    wordT    memData;
    pcT      pcNext;
    memAddrT memAddr;

    // low bits of the alu result address data memory
    assign memAddr   = memAddrT'(aluResult);
    assign memWrEn   = wrMem;
    assign memWrAddr = memAddr;
    assign memWrData = rtData;

    controlUnit uControl (
        .clk       (clk),
        .rst       (rst),
        .opcode    (instr[31:26]),
        .func      (instr[4:0]),
        .irq       (irq),
        .aluOp     (aluOp),
        .brOp      (brOp),
        .aluSrc    (aluSrc),
        .regAluOut (regAluOut),
        .rdMem     (rdMem),
        .wrMem     (wrMem),
        .wrReg     (wrReg),
        .mToReg    (mToReg),
        .linkSel   (linkSel),
        .updPc     (updPc),
        .isCmov    (isCmov)
    );

    aluExec uAlu (
        .rsData    (rsData),
        .rtData    (rtData),
        .imm       (instr[15:0]),
        .aluSrc    (aluSrc),
        .aluOp     (aluOp),
        .aluResult (aluResult),
        .rtZero    (rtZero)
    );

    branchUnit uBranch (
        .clk    (clk),
        .rst    (rst),
        .updPc  (updPc),
        .brOp   (brOp),
        .rsData (rsData),
        .offset (instr[15:0]),
        .pc     (pc),
        .pcNext (pcNext)
    );

    regFile uRegs (
        .clk       (clk),
        .rst       (rst),
        .rsIdx     (instr[25:21]),
        .rtIdx     (instr[20:16]),
        .rdIdx     (instr[15:11]),
        .wrReg     (wrReg),
        .regAluOut (regAluOut),
        .linkSel   (linkSel),
        .mToReg    (mToReg),
        .isCmov    (isCmov),
        .rtZero    (rtZero),
        .aluResult (aluResult),
        .memData   (memData),
        .pcNext    (pcNext),
        .rsData    (rsData),
        .rtData    (rtData),
        .wrEn      (regWrEn),
        .wrAddr    (regWrAddr),
        .wrData    (regWrData)
    );

    dataMem uMem (
        .clk   (clk),
        .rdMem (rdMem),
        .wrMem (wrMem),
        .addr  (memAddr),
        .wData (rtData),
        .rData (memData)
    );

endmodule

// File: logic/dataMem.sv
`timescale 1ns/100ps

module dataMem (
    input  logic            clk,
    input  logic            rdMem,
    input  logic            wrMem,
    input  cpuPkg::memAddrT addr,
    input  cpuPkg::wordT    wData,
    output cpuPkg::wordT    rData
);
    import cpuPkg::*;

    wordT mem [memDepth];

    initial begin
        for (int i = 0; i < memDepth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wrMem) begin
            mem[addr] <= wData;
        end
        // read data lands one edge after rdMem
        if (rdMem) begin
            rData <= mem[addr];
        end
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic           clk,
    input  logic           rst,
    input  cpuPkg::regIdxT rsIdx,
    input  cpuPkg::regIdxT rtIdx,
    input  cpuPkg::regIdxT rdIdx,
    input  logic           wrReg,
    input  logic           regAluOut,
    input  logic           linkSel,
    input  logic           mToReg,
    input  logic           isCmov,
    input  logic           rtZero,
    input  cpuPkg::wordT   aluResult,
    input  cpuPkg::wordT   memData,
    input  cpuPkg::pcT     pcNext,
    output cpuPkg::wordT   rsData,
    output cpuPkg::wordT   rtData,
    output logic           wrEn,
    output cpuPkg::regIdxT wrAddr,
    output cpuPkg::wordT   wrData
);
    import cpuPkg::*;

    wordT regs [32];

    // r0 always reads zero
    assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
    assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

    assign wrData = mToReg ? memData : (linkSel ? wordT'(pcNext) : aluResult);
    assign wrAddr = linkSel ? linkReg : (regAluOut ? rdIdx : rtIdx);
    // cmov drops the write when rt is zero
    assign wrEn   = wrReg && !(isCmov && rtZero);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

// File: logic/branchUnit.sv
`timescale 1ns/100ps

module branchUnit (
    input  logic         clk,
    input  logic         rst,
    input  logic         updPc,
    input  cpuPkg::brOpT brOp,
    input  cpuPkg::wordT rsData,
    input  logic [15:0]  offset,
    output cpuPkg::pcT   pc,
    output cpuPkg::pcT   pcNext
);
    import cpuPkg::*;

    logic taken;
    logic rsNeg;
    logic rsIsZero;
    pcT   brTarget;

    assign rsNeg    = rsData[31];
    assign rsIsZero = (rsData == '0);
    assign pcNext   = pc + 8'd1;
    // offset counts from the fall-through address
    assign brTarget = pcT'({8'h00, pcNext} + offset);

    always_comb begin
        case (brOp)
            brAlways: taken = 1'b1;
            brMinus:  taken = rsNeg;
            brPlus:   taken = !rsNeg && !rsIsZero;
            brZero:   taken = rsIsZero;
            brNone:   taken = 1'b0;
            default:  taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (updPc) begin
            pc <= taken ? brTarget : pcNext;
        end
    end

endmodule

// File: logic/aluExec.sv
`timescale 1ns/100ps

module aluExec (
    input  cpuPkg::wordT  rsData,
    input  cpuPkg::wordT  rtData,
    input  logic [15:0]   imm,
    input  logic          aluSrc,
    input  cpuPkg::aluOpT aluOp,
    output cpuPkg::wordT  aluResult,
    output logic          rtZero
);
    import cpuPkg::*;

    wordT       opA;
    wordT       opB;
    wordT       extImm;
    wordT       popCnt;
    logic [4:0] shAmt;

    assign extImm = {{16{imm[15]}}, imm};
    // aluSrc high picks the register operand
    assign opA    = rsData;
    assign opB    = aluSrc ? rtData : extImm;
    assign shAmt  = opB[4:0];
    assign rtZero = (rtData == '0);

    always_comb begin
        popCnt = '0;
        for (int i = 0; i < 32; i++) begin
            popCnt = popCnt + wordT'(opA[i]);
        end
    end

    always_comb begin
        case (aluOp)
            aluAdd: aluResult = opA + opB;
            aluSub: aluResult = opA - opB;
            aluAnd: aluResult = opA & opB;
            aluOr:  aluResult = opA | opB;
            aluXor: aluResult = opA ^ opB;
            aluNor: aluResult = ~(opA | opB);
            aluSll: aluResult = opA << shAmt;
            aluSrl: aluResult = opA >> shAmt;
            aluSra: aluResult = wordT'($signed(opA) >>> shAmt);
            aluSlt: aluResult = wordT'($signed(opA) < $signed(opB));
            aluSgt: aluResult = wordT'($signed(opA) > $signed(opB));
            aluNot: aluResult = ~opA;
            aluInc: aluResult = opA + 32'd1;
            aluDec: aluResult = opA - 32'd1;
            aluPop: aluResult = popCnt;
            // low half of operand b moves to the top
            aluLui: aluResult = {opB[15:0], 16'h0000};
            default: aluResult = opA + opB;
        endcase
    end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
    input  logic           clk,
    input  logic           rst,
    input  cpuPkg::opcodeT opcode,
    input  logic [4:0]     func,
    input  logic           irq,
    output cpuPkg::aluOpT  aluOp,
    output cpuPkg::brOpT   brOp,
    output logic           aluSrc,
    output logic           regAluOut,
    output logic           rdMem,
    output logic           wrMem,
    output logic           wrReg,
    output logic           mToReg,
    output logic           linkSel,
    output logic           updPc,
    output logic           isCmov
);
    import cpuPkg::*;

    ctrlStateT  state;
    phaseT      phase;
    phaseT      donePh;
    phaseT      wrPh;
    logic       doesWr;
    logic       isLd;
    logic       isSt;
    logic       isHalt;
    logic       cmovCls;
    logic       callCls;
    logic       inExec;
    opcodeT     opcM1;
    logic [4:0] funcM1;

    assign opcM1  = opcode - 6'd1;
    assign funcM1 = func - 5'd1;
    assign inExec = (state == stExec);

    // per-class decode: levels plus the phases of write and pc update
    always_comb begin
        aluOp     = aluAdd;
        brOp      = brNone;
        aluSrc    = 1'b0;
        regAluOut = 1'b0;
        doesWr    = 1'b0;
        wrPh      = ph1;
        donePh    = ph2;
        isLd      = 1'b0;
        isSt      = 1'b0;
        isHalt    = 1'b0;
        cmovCls   = 1'b0;
        callCls   = 1'b0;
        case (opcode)
            opR: begin
                aluOp     = funcM1[3:0];
                aluSrc    = 1'b1;
                regAluOut = 1'b1;
                doesWr    = 1'b1;
            end
            opAddi, opSubi, opAndi, opOri, opXori, opNori, opSli, opSrli,
            opSrai, opSlti, opSgti, opNoti, opInci, opDeci, opHami: begin
                aluOp  = opcM1[3:0];
                doesWr = 1'b1;
            end
            opLui: begin
                aluOp  = aluLui;
                doesWr = 1'b1;
            end
            opLd: begin
                isLd   = 1'b1;
                doesWr = 1'b1;
                wrPh   = ph2;
                donePh = ph3;
            end
            opSt: begin
                isSt   = 1'b1;
                donePh = ph3;
            end
            opMove: begin
                aluSrc    = 1'b1;
                regAluOut = 1'b1;
                doesWr    = 1'b1;
            end
            // extra settling phase before the gated write
            opCmov: begin
                aluSrc    = 1'b1;
                regAluOut = 1'b1;
                doesWr    = 1'b1;
                cmovCls   = 1'b1;
                wrPh      = ph2;
                donePh    = ph3;
            end
            opBr:  brOp = brAlways;
            opBmi: brOp = brMinus;
            opBpl: brOp = brPlus;
            opBz:  brOp = brZero;
            opHalt: begin
                isHalt = 1'b1;
                donePh = ph1;
            end
            opNop: donePh = ph1;
            opCall: begin
                brOp    = brAlways;
                doesWr  = 1'b1;
                callCls = 1'b1;
            end
            // unknown opcodes retire like nop
            default: donePh = ph1;
        endcase
    end

    assign wrReg   = inExec && doesWr && (phase == wrPh);
    assign rdMem   = inExec && isLd && (phase == ph1);
    assign mToReg  = inExec && isLd && (phase == ph2);
    assign wrMem   = inExec && isSt && (phase == ph2);
    assign isCmov  = inExec && cmovCls;
    assign linkSel = inExec && callCls;
    assign updPc   = inExec && (phase == donePh);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= stIdle;
            phase <= ph0;
        end else begin
            case (state)
                stIdle: state <= stFetch;
                stFetch: begin
                    state <= stExec;
                    phase <= ph0;
                end
                stExec: begin
                    if (updPc) begin
                        state <= stFetch;
                        phase <= ph0;
                    end else if (!(isHalt && !irq)) begin
                        // halt parks in ph0 until irq
                        phase <= phaseT'(phase + 2'd1);
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// File: logic/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [7:0]  pcT;
    typedef logic [4:0]  regIdxT;
    typedef logic [7:0]  memAddrT;
    typedef logic [5:0]  opcodeT;
    typedef logic [3:0]  aluOpT;

    // alu operations, immediate opcode n and func n both map to n-1
    localparam aluOpT aluAdd = 4'd0;
    localparam aluOpT aluSub = 4'd1;
    localparam aluOpT aluAnd = 4'd2;
    localparam aluOpT aluOr  = 4'd3;
    localparam aluOpT aluXor = 4'd4;
    localparam aluOpT aluNor = 4'd5;
    localparam aluOpT aluSll = 4'd6;
    localparam aluOpT aluSrl = 4'd7;
    localparam aluOpT aluSra = 4'd8;
    localparam aluOpT aluSlt = 4'd9;
    localparam aluOpT aluSgt = 4'd10;
    localparam aluOpT aluNot = 4'd11;
    localparam aluOpT aluInc = 4'd12;
    localparam aluOpT aluDec = 4'd13;
    localparam aluOpT aluPop = 4'd14;
    localparam aluOpT aluLui = 4'd15;

    typedef enum logic [2:0] {
        brAlways = 3'd0,
        brMinus  = 3'd1,
        brPlus   = 3'd2,
        brZero   = 3'd3,
        brNone   = 3'd4
    } brOpT;

    typedef enum logic [1:0] {
        stFetch = 2'd0,
        stExec  = 2'd1,
        stIdle  = 2'd2
    } ctrlStateT;

    typedef enum logic [1:0] {
        ph0 = 2'd0,
        ph1 = 2'd1,
        ph2 = 2'd2,
        ph3 = 2'd3
    } phaseT;

    localparam opcodeT opR    = 6'h00;
    localparam opcodeT opAddi = 6'h01;
    localparam opcodeT opSubi = 6'h02;
    localparam opcodeT opAndi = 6'h03;
    localparam opcodeT opOri  = 6'h04;
    localparam opcodeT opXori = 6'h05;
    localparam opcodeT opNori = 6'h06;
    localparam opcodeT opSli  = 6'h07;
    localparam opcodeT opSrli = 6'h08;
    localparam opcodeT opSrai = 6'h09;
    localparam opcodeT opSlti = 6'h0a;
    localparam opcodeT opSgti = 6'h0b;
    localparam opcodeT opNoti = 6'h0c;
    localparam opcodeT opInci = 6'h0d;
    localparam opcodeT opDeci = 6'h0e;
    localparam opcodeT opHami = 6'h0f;
    localparam opcodeT opLui  = 6'h10;
    localparam opcodeT opLd   = 6'h11;
    localparam opcodeT opSt   = 6'h12;
    localparam opcodeT opMove = 6'h14;
    localparam opcodeT opCmov = 6'h15;
    localparam opcodeT opBr   = 6'h20;
    localparam opcodeT opBmi  = 6'h21;
    localparam opcodeT opBpl  = 6'h22;
    localparam opcodeT opBz   = 6'h23;
    localparam opcodeT opHalt = 6'h24;
    localparam opcodeT opNop  = 6'h25;
    localparam opcodeT opCall = 6'h26;

    localparam regIdxT linkReg  = 5'd16;
    localparam int     memDepth = 256;

endpackage
